//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_hyperbus
FILELIST  = tb.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a run without the pass line fails
run: compile
	./$(BIN) | tee /dev/stderr | grep "TESTS PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- axil_pkg.sv
//////////////////////////////
// axi4-lite types
// address, data, strobe and response widths plus the
// request and response channel bundles of the slave port
//////////////////////////////

package axil_pkg;

    typedef logic [31:0] axil_addr_t;   // byte address
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;   // one bit per byte lane
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        logic       valid;
        axil_addr_t addr;
    } axil_ax_t;                        // shared by aw and ar

    typedef struct packed {
        logic       valid;
        axil_data_t data;
        axil_strb_t strb;
    } axil_w_t;

    typedef struct packed {
        logic       valid;
        axil_resp_t resp;
    } axil_b_t;

    typedef struct packed {
        logic       valid;
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

    // master to slave
    typedef struct packed {
        axil_ax_t aw;
        axil_w_t  w;
        logic     b_ready;
        axil_ax_t ar;
        logic     r_ready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic    aw_ready;
        logic    w_ready;
        axil_b_t b;
        logic    ar_ready;
        axil_r_t r;
    } axil_rsp_t;

endpackage

//--- hyper_axil_front.sv
//////////////////////////////
// axi4-lite front end
// turns single-word reads and writes into phy transactions,
// answers unmapped chips with decerr
//////////////////////////////

module hyper_axil_front #(
    parameter int unsigned NR_CS = 2
) (
    input  logic                    clk0,
    input  logic                    rst_ni,
    input  axil_pkg::axil_req_t     axil_req_i,
    output axil_pkg::axil_rsp_t     axil_rsp_o,
    output logic                    trans_valid_o,
    output hyper_pkg::hyper_trans_t trans_o,
    input  logic                    trans_ready_i,
    input  logic                    rd_valid_i,
    input  axil_pkg::axil_data_t    rd_data_i,
    input  logic                    done_i
);

    import axil_pkg::*;
    import hyper_pkg::*;

    localparam int unsigned ADDR_W = $bits(axil_addr_t);
    localparam int unsigned SEL_W  = ADDR_W - CHIP_ADDR_BITS;

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT_PHY, RESP} front_state_e;

    front_state_e     state_q;
    logic             is_write_q;
    axil_resp_t       resp_q;
    axil_data_t       rdata_q;
    hyper_trans_t     trans_q;
    logic             wr_accept;
    logic             rd_accept;
    axil_addr_t       addr;
    logic [SEL_W-1:0] chip_sel;
    logic             decerr;

    // write wins when both arrive together
    assign wr_accept = (state_q == IDLE) && axil_req_i.aw.valid && axil_req_i.w.valid;
    assign rd_accept = (state_q == IDLE) && axil_req_i.ar.valid
                       && !axil_req_i.aw.valid && !axil_req_i.w.valid;

    assign addr     = wr_accept ? axil_req_i.aw.addr : axil_req_i.ar.addr;
    assign chip_sel = addr[ADDR_W-1:CHIP_ADDR_BITS];
    assign decerr   = chip_sel >= SEL_W'(NR_CS);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            is_write_q <= 1'b0;
            resp_q     <= RESP_OKAY;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_accept || rd_accept) begin
                        is_write_q <= wr_accept;
                        resp_q     <= decerr ? RESP_DECERR : RESP_OKAY;
                        state_q    <= decerr ? RESP : ISSUE;   // no bus cycle on decerr
                    end
                end
                ISSUE:    if (trans_ready_i) state_q <= WAIT_PHY;
                WAIT_PHY: if (is_write_q ? done_i : rd_valid_i) state_q <= RESP;
                RESP: begin
                    if (is_write_q ? axil_req_i.b_ready : axil_req_i.r_ready) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // transaction and read data payload
    always_ff @(posedge clk0) begin
        if (wr_accept || rd_accept) begin
            trans_q.write  <= wr_accept;
            trans_q.haddr  <= addr[CHIP_ADDR_BITS-1:1];
            trans_q.cs_idx <= addr[CHIP_ADDR_BITS +: $bits(hyper_cs_idx_t)];
            trans_q.data   <= axil_req_i.w.data;
            trans_q.mask   <= ~axil_req_i.w.strb;      // strobe off = masked byte
            rdata_q        <= '0;
        end
        if (state_q == WAIT_PHY && rd_valid_i) begin
            rdata_q <= rd_data_i;
        end
    end

    assign trans_valid_o = (state_q == ISSUE);
    assign trans_o       = trans_q;

    always_comb begin
        axil_rsp_o          = '0;
        axil_rsp_o.aw_ready = wr_accept;
        axil_rsp_o.w_ready  = wr_accept;
        axil_rsp_o.ar_ready = rd_accept;
        axil_rsp_o.b.valid  = (state_q == RESP) && is_write_q;
        axil_rsp_o.b.resp   = resp_q;
        axil_rsp_o.r.valid  = (state_q == RESP) && !is_write_q;
        axil_rsp_o.r.data   = rdata_q;
        axil_rsp_o.r.resp   = resp_q;
    end

endmodule

//--- hyper_cmd_addr.sv
//////////////////////////////
// hyperbus command/address
// packs a transaction into the 48-bit ca word
//////////////////////////////

module hyper_cmd_addr (
    input  hyper_pkg::hyper_trans_t trans_i,
    output hyper_pkg::hyper_ca_t    ca_o
);

    import hyper_pkg::*;

    localparam int unsigned UPPER_W = CA_UPPER_MSB - CA_UPPER_LSB + 1;
    localparam int unsigned HADDR_W = $bits(hyper_haddr_t);

    logic [UPPER_W-1:0] upper_addr;

    // row and upper column bits, zero extended
    assign upper_addr = UPPER_W'(trans_i.haddr[HADDR_W-1:CA_LOWER_BITS]);

    always_comb begin
        ca_o = '0;                                  // reserved bits stay zero
        ca_o[CA_RW_BIT]    = ~trans_i.write;
        ca_o[CA_SPACE_BIT] = 1'b0;                  // memory space
        ca_o[CA_BURST_BIT] = 1'b1;                  // linear burst
        ca_o[CA_UPPER_MSB:CA_UPPER_LSB] = upper_addr;
        ca_o[CA_LOWER_BITS-1:0] = trans_i.haddr[CA_LOWER_BITS-1:0];
    end

endmodule

//--- hyper_phy.sv
//////////////////////////////
// hyperbus phy
// runs one transaction at a time: cs, command/address,
// fixed double latency, two data halfwords, recovery
//////////////////////////////

module hyper_phy #(
    parameter int unsigned NR_CS       = 2,
    parameter int unsigned WAIT_CYCLES = 6
) (
    input  logic                    clk0,
    input  logic                    rst_ni,
    // transaction channel
    input  logic                    trans_valid_i,
    input  hyper_pkg::hyper_trans_t trans_i,
    output logic                    trans_ready_o,
    // completion
    output logic                    rd_valid_o,
    output axil_pkg::axil_data_t    rd_data_o,
    output logic                    done_o,
    // bus pins
    output logic [NR_CS-1:0]        hyper_cs_no,
    output logic                    hyper_ck_en_o,
    output hyper_pkg::hyper_word_t  hyper_dq_o,
    input  hyper_pkg::hyper_word_t  hyper_dq_i,
    output logic                    hyper_dq_oe_o,
    output hyper_pkg::hyper_mask_t  hyper_rwds_o,
    input  logic                    hyper_rwds_i,
    output logic                    hyper_rwds_oe_o,
    output logic                    hyper_reset_no
);

    import hyper_pkg::*;

    localparam int unsigned CNT_W = $clog2(WAIT_CYCLES) + 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WAIT_CYCLES - 1);

    hyper_state_e     state_q;
    hyper_trans_t     trans_q;      // latched transaction
    hyper_ca_t        ca;
    hyper_word_t      ca_word;
    logic [CNT_W-1:0] wait_cnt_q;
    logic [1:0]       ca_sel_q;     // which ca halfword is on dq
    logic             hw_cnt_q;     // 0 = upper halfword
    logic             accept;
    logic             cs_active;

    assign accept = trans_valid_i && trans_ready_o;
    assign hyper_reset_no = 1'b1;   // chips never reset from here

    hyper_cmd_addr i_cmd_addr (
        .trans_i ( trans_q ),
        .ca_o    ( ca      )
    );

    always_comb begin
        case (ca_sel_q)
            2'd0:    ca_word = ca[47:32];
            2'd1:    ca_word = ca[31:16];
            default: ca_word = ca[15:0];
        endcase
    end

    // transaction sequencing
    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= STANDBY;
            trans_ready_o <= 1'b0;
            wait_cnt_q    <= '0;
            ca_sel_q      <= '0;
            hw_cnt_q      <= 1'b0;
            rd_valid_o    <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            rd_valid_o <= 1'b0;
            done_o     <= 1'b0;
            case (state_q)
                STANDBY: begin
                    trans_ready_o <= 1'b1;
                    if (accept) begin
                        trans_ready_o <= 1'b0;
                        ca_sel_q      <= '0;
                        state_q       <= CMD_ADDR;
                    end
                end
                CMD_ADDR: begin
                    ca_sel_q <= ca_sel_q + 2'd1;
                    if (ca_sel_q == 2'd2) begin
                        wait_cnt_q <= CNT_LAST;
                        state_q    <= LATENCY2;
                    end
                end
                LATENCY2: begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                    if (wait_cnt_q == '0) begin
                        wait_cnt_q <= CNT_LAST;
                        state_q    <= LATENCY;
                    end
                end
                LATENCY: begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                    if (wait_cnt_q == '0) begin
                        hw_cnt_q <= 1'b0;
                        state_q  <= trans_q.write ? DATA_W : DATA_R;
                    end
                end
                DATA_W, DATA_R: begin
                    hw_cnt_q <= 1'b1;
                    if (hw_cnt_q) begin
                        done_o     <= (state_q == DATA_W);
                        rd_valid_o <= (state_q == DATA_R);
                        wait_cnt_q <= CNT_LAST;
                        state_q    <= RECOVER;
                    end
                end
                RECOVER: begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                    if (wait_cnt_q == '0) begin
                        trans_ready_o <= 1'b1;
                        state_q       <= STANDBY;
                    end
                end
                default: state_q <= STANDBY;
            endcase
        end
    end

    // transaction latch and read data capture
    always_ff @(posedge clk0) begin
        if (accept) begin
            trans_q <= trans_i;
        end
        if (state_q == DATA_R && hyper_rwds_i) begin   // rwds marks valid data
            if (!hw_cnt_q) begin
                rd_data_o[31:16] <= hyper_dq_i;
            end else begin
                rd_data_o[15:0]  <= hyper_dq_i;
            end
        end
    end

    assign cs_active = state_q inside {CMD_ADDR, LATENCY2, LATENCY, DATA_W, DATA_R};
    assign hyper_ck_en_o = cs_active;

    always_comb begin
        for (int i = 0; i < NR_CS; i++) begin
            hyper_cs_no[i] = !(cs_active && trans_q.cs_idx == hyper_cs_idx_t'(i));
        end
    end

    // bus drivers
    assign hyper_dq_oe_o   = (state_q == CMD_ADDR) || (state_q == DATA_W);
    assign hyper_rwds_oe_o = (state_q == DATA_W);

    always_comb begin
        hyper_dq_o   = '0;
        hyper_rwds_o = '0;      // rwds low outside the write data phase
        if (state_q == CMD_ADDR) begin
            hyper_dq_o = ca_word;
        end else if (state_q == DATA_W) begin
            hyper_dq_o   = trans_q.data[~hw_cnt_q];
            hyper_rwds_o = trans_q.mask[~hw_cnt_q];
        end
    end

endmodule

//--- hyper_pkg.sv
//////////////////////////////
// hyperbus types
// bus widths, the transaction handed to the phy, the
// phy state encoding and the command/address layout
//////////////////////////////

package hyper_pkg;

    typedef logic [15:0] hyper_word_t;  // one halfword, both ck edges
    typedef logic [1:0]  hyper_mask_t;  // set bit = byte not written
    typedef logic [47:0] hyper_ca_t;
    typedef logic [22:0] hyper_haddr_t; // halfword address inside a chip
    typedef logic [1:0]  hyper_cs_idx_t;

    // byte address width of one chip
    localparam int unsigned CHIP_ADDR_BITS = 24;

    // command/address bit positions
    localparam int unsigned CA_RW_BIT     = 47; // 1 = read
    localparam int unsigned CA_SPACE_BIT  = 46; // 0 = memory
    localparam int unsigned CA_BURST_BIT  = 45; // 1 = linear
    localparam int unsigned CA_UPPER_MSB  = 44;
    localparam int unsigned CA_UPPER_LSB  = 16;
    localparam int unsigned CA_LOWER_BITS = 3;  // low halfword address bits

    // index 1 is the upper halfword and goes out first
    typedef struct packed {
        logic                   write;
        hyper_haddr_t           haddr;
        hyper_cs_idx_t          cs_idx;
        hyper_word_t [1:0]      data;
        hyper_mask_t [1:0]      mask;
    } hyper_trans_t;

    typedef enum logic [2:0] {
        STANDBY,
        CMD_ADDR,
        LATENCY2,    // second latency count, always taken
        LATENCY,
        DATA_W,
        DATA_R,
        RECOVER      // read-write recovery with cs high
    } hyper_state_e;

endpackage

//--- hyperbus_props.sv
//////////////////////////////
// hyperbus phy properties
// chip select, dq and rwds drive rules
//////////////////////////////

module hyperbus_props #(
    parameter int unsigned NR_CS = 2
) (
    input logic                    clk0,
    input logic                    rst_ni,
    input logic [NR_CS-1:0]        hyper_cs_no,
    input logic                    hyper_dq_oe_o,
    input logic                    hyper_rwds_oe_o,
    input hyper_pkg::hyper_state_e state_q
);

    timeunit 1ns;
    timeprecision 1ps;

    import hyper_pkg::*;

    int unsigned fail_cnt = 0;  // failed assertions so far

    one_cs_low: assert property (@(posedge clk0) disable iff (!rst_ni)
        $countones(~hyper_cs_no) <= 1)
        else begin
            fail_cnt++;
            $error("more than one chip select low");
        end

    dq_oe_in_cs: assert property (@(posedge clk0) disable iff (!rst_ni)
        hyper_dq_oe_o |-> (hyper_cs_no != '1))
        else begin
            fail_cnt++;
            $error("dq driven with no chip selected");
        end

    // write mask only toward a selected chip
    rwds_oe_in_write: assert property (@(posedge clk0) disable iff (!rst_ni)
        hyper_rwds_oe_o |-> (state_q == DATA_W) && (hyper_cs_no != '1))
        else begin
            fail_cnt++;
            $error("rwds driven outside the write data phase of a selected chip");
        end

endmodule

bind hyper_phy hyperbus_props #(
    .NR_CS ( NR_CS )
) i_props (
    .clk0            ( clk0            ),
    .rst_ni          ( rst_ni          ),
    .hyper_cs_no     ( hyper_cs_no     ),
    .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
    .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
    .state_q         ( state_q         )
);

//--- hyperbus_top.sv
//////////////////////////////
// hyperbus controller top
// axi4-lite front end feeding the hyperbus phy
//////////////////////////////

module hyperbus_top #(
    parameter int unsigned NR_CS       = 2,
    parameter int unsigned WAIT_CYCLES = 6
) (
    input  logic                   clk0,
    input  logic                   rst_ni,
    input  axil_pkg::axil_req_t    axil_req_i,
    output axil_pkg::axil_rsp_t    axil_rsp_o,
    output logic [NR_CS-1:0]       hyper_cs_no,
    output logic                   hyper_ck_en_o,
    output hyper_pkg::hyper_word_t hyper_dq_o,
    input  hyper_pkg::hyper_word_t hyper_dq_i,
    output logic                   hyper_dq_oe_o,
    output hyper_pkg::hyper_mask_t hyper_rwds_o,
    input  logic                   hyper_rwds_i,
    output logic                   hyper_rwds_oe_o,
    output logic                   hyper_reset_no
);

    import axil_pkg::*;
    import hyper_pkg::*;

    hyper_trans_t trans;
    logic         trans_valid;
    logic         trans_ready;
    logic         rd_valid;
    axil_data_t   rd_data;
    logic         done;

    hyper_axil_front #(
        .NR_CS ( NR_CS )
    ) i_front (
        .clk0          ( clk0        ),
        .rst_ni        ( rst_ni      ),
        .axil_req_i    ( axil_req_i  ),
        .axil_rsp_o    ( axil_rsp_o  ),
        .trans_valid_o ( trans_valid ),
        .trans_o       ( trans       ),
        .trans_ready_i ( trans_ready ),
        .rd_valid_i    ( rd_valid    ),
        .rd_data_i     ( rd_data     ),
        .done_i        ( done        )
    );

    hyper_phy #(
        .NR_CS       ( NR_CS       ),
        .WAIT_CYCLES ( WAIT_CYCLES )
    ) i_phy (
        .clk0            ( clk0            ),
        .rst_ni          ( rst_ni          ),
        .trans_valid_i   ( trans_valid     ),
        .trans_i         ( trans           ),
        .trans_ready_o   ( trans_ready     ),
        .rd_valid_o      ( rd_valid        ),
        .rd_data_o       ( rd_data         ),
        .done_o          ( done            ),
        .hyper_cs_no     ( hyper_cs_no     ),
        .hyper_ck_en_o   ( hyper_ck_en_o   ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_i      ( hyper_dq_i      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_i    ( hyper_rwds_i    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
        .hyper_reset_no  ( hyper_reset_no  )
    );

endmodule

//--- tb.f
axil_pkg.sv
hyper_pkg.sv
hyper_cmd_addr.sv
hyper_phy.sv
hyper_axil_front.sv
hyperbus_top.sv
tb_hyperram_model.sv
hyperbus_props.sv
tb_hyperbus.sv

//--- tb_hyperbus.sv
//////////////////////////////
// hyperbus controller testbench
// axi4-lite table driven reads and writes against
// two hyperram models and a shadow byte memory
//////////////////////////////

module tb_hyperbus;

    timeunit 1ns;
    timeprecision 1ps;

    import axil_pkg::*;
    import hyper_pkg::*;

    localparam int unsigned NR_CS           = 2;
    localparam int unsigned WAIT_CYCLES     = 6;
    localparam int unsigned RESET_CYCLES    = 5;
    localparam int unsigned CYCLES_PER_TEST = 40;
    localparam int unsigned CS_LOW_CYCLES   = 3 + 2 * WAIT_CYCLES + 2;  // ca, latency, data
    localparam int unsigned WR_DATA_CYCLES  = 2;    // two halfwords with a mask
    localparam int unsigned WINDOW          = 256;  // bytes used per chip
    localparam int unsigned N_RANDOM        = 8;

    typedef struct packed {
        logic       write;
        axil_addr_t addr;
        axil_data_t data;
        axil_strb_t strb;
        axil_data_t exp_data;
        axil_resp_t exp_resp;
        logic [3:0] hold;           // cycles with bready/rready held low
    } test_entry_t;

    logic             clk0 = 1'b0;
    logic             rst_ni;
    axil_req_t        axil_req;
    axil_rsp_t        axil_rsp;
    logic [NR_CS-1:0] hyper_cs_n;
    logic             hyper_ck_en;
    hyper_word_t      hyper_dq_out;
    hyper_word_t      hyper_dq_in;
    logic             hyper_dq_oe;
    hyper_mask_t      hyper_rwds_out;
    logic             hyper_rwds_in;
    logic             hyper_rwds_oe;
    logic             hyper_reset_n;
    hyper_word_t      model_dq [NR_CS];
    logic [NR_CS-1:0] model_rwds;

    test_entry_t table_q [$];
    logic [7:0]  shadow [NR_CS][WINDOW];
    int unsigned cs_low_cnt [NR_CS] = '{default: 0};
    int unsigned ck_en_cnt     = 0;
    int unsigned rwds_oe_cnt   = 0;
    int unsigned reset_low_cnt = 0;
    int unsigned cycle_cnt     = 0;
    int unsigned timeout_limit = 0;
    int unsigned err_cnt       = 0;
    int unsigned check_cnt     = 0;
    integer      seed          = 32'h3cb5;

    always #50 clk0 = ~clk0;

    hyperbus_top #(
        .NR_CS       ( NR_CS       ),
        .WAIT_CYCLES ( WAIT_CYCLES )
    ) dut (
        .clk0            ( clk0           ),
        .rst_ni          ( rst_ni         ),
        .axil_req_i      ( axil_req       ),
        .axil_rsp_o      ( axil_rsp       ),
        .hyper_cs_no     ( hyper_cs_n     ),
        .hyper_ck_en_o   ( hyper_ck_en    ),
        .hyper_dq_o      ( hyper_dq_out   ),
        .hyper_dq_i      ( hyper_dq_in    ),
        .hyper_dq_oe_o   ( hyper_dq_oe    ),
        .hyper_rwds_o    ( hyper_rwds_out ),
        .hyper_rwds_i    ( hyper_rwds_in  ),
        .hyper_rwds_oe_o ( hyper_rwds_oe  ),
        .hyper_reset_no  ( hyper_reset_n  )
    );

    for (genvar c = 0; c < NR_CS; c++) begin : g_model
        tb_hyperram_model #(
            .WAIT_CYCLES ( WAIT_CYCLES ),
            .FILL_SEED   ( 8'(8'h17 + 8'h40 * c) )
        ) i_model (
            .clk0    ( clk0           ),
            .cs_ni   ( hyper_cs_n[c]  ),
            .dq_oe_i ( hyper_dq_oe    ),
            .dq_i    ( hyper_dq_out   ),
            .rwds_i  ( hyper_rwds_out ),
            .dq_o    ( model_dq[c]    ),
            .rwds_o  ( model_rwds[c]  )
        );
    end

    // idle models drive zero
    always_comb begin
        hyper_dq_in = '0;
        for (int c = 0; c < NR_CS; c++) begin
            hyper_dq_in = hyper_dq_in | model_dq[c];
        end
    end
    assign hyper_rwds_in = |model_rwds;

    always @(posedge clk0) begin
        cycle_cnt <= cycle_cnt + 1;
        for (int c = 0; c < NR_CS; c++) begin
            if (!hyper_cs_n[c]) cs_low_cnt[c] <= cs_low_cnt[c] + 1;
        end
        if (hyper_ck_en) ck_en_cnt <= ck_en_cnt + 1;
        if (hyper_rwds_oe) rwds_oe_cnt <= rwds_oe_cnt + 1;
        if (!hyper_reset_n) reset_low_cnt <= reset_low_cnt + 1;
        if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: tests did not finish within %0d cycles", timeout_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic axil_resp_t resp_for(axil_addr_t addr);
        return ((addr >> CHIP_ADDR_BITS) >= NR_CS) ? RESP_DECERR : RESP_OKAY;
    endfunction

    function automatic axil_data_t shadow_word(axil_addr_t addr);
        int unsigned c;
        int unsigned off;
        c   = addr >> CHIP_ADDR_BITS;
        off = addr[7:0] & 8'hfc;
        if (resp_for(addr) != RESP_OKAY) return '0;   // decerr reads return zero
        return {shadow[c][off + 3], shadow[c][off + 2], shadow[c][off + 1], shadow[c][off]};
    endfunction

    task automatic add_write(axil_addr_t addr, axil_data_t data, axil_strb_t strb,
                             logic [3:0] hold);
        test_entry_t e;
        int unsigned c;
        int unsigned off;
        e = '{write: 1'b1, addr: addr, data: data, strb: strb, exp_data: '0,
              exp_resp: resp_for(addr), hold: hold};
        c   = addr >> CHIP_ADDR_BITS;
        off = addr[7:0] & 8'hfc;
        if (e.exp_resp == RESP_OKAY) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[c][off + b] = data[8 * b +: 8];
            end
        end
        table_q.push_back(e);
    endtask

    task automatic add_read(axil_addr_t addr, logic [3:0] hold);
        test_entry_t e;
        e = '{write: 1'b0, addr: addr, data: '0, strb: '0, exp_data: shadow_word(addr),
              exp_resp: resp_for(addr), hold: hold};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        axil_addr_t rnd_addr [N_RANDOM];
        axil_addr_t chip;
        axil_addr_t off;
        add_write(32'h0000_0010, 32'hcafe_f00d, 4'hf, 0);     // plain write and read back
        add_read (32'h0000_0010, 0);
        add_write(32'h0000_0040, 32'h1122_3344, 4'hf, 0);
        add_write(32'h0000_0040, 32'haabb_ccdd, 4'b0101, 0);  // partial strobes
        add_read (32'h0000_0040, 0);
        add_write(32'h0000_0044, 32'h5566_7788, 4'hf, 0);
        add_write(32'h0000_0044, 32'h9900_0000, 4'b1000, 0);
        add_read (32'h0000_0044, 0);
        add_write(32'h0000_0080, 32'h0bad_0000, 4'hf, 0);     // same offset, both chips
        add_write(32'h0100_0080, 32'h1bad_1111, 4'hf, 0);
        add_read (32'h0000_0080, 0);
        add_read (32'h0100_0080, 0);
        add_write(32'h0200_0010, 32'hdead_beef, 4'hf, 0);     // no chip behind these
        add_read (32'h0200_0010, 0);
        add_read (32'hff00_0040, 0);
        add_write(32'h0100_00c0, 32'h0f1e_2d3c, 4'hf, 4);     // back-pressure
        add_read (32'h0100_00c0, 5);
        for (int i = 0; i < N_RANDOM; i++) begin
            chip        = 32'($random(seed)) & 32'h1;
            off         = 32'($random(seed)) & 32'hfc;
            rnd_addr[i] = (chip << CHIP_ADDR_BITS) | off;
            add_write(rnd_addr[i], 32'($random(seed)), 4'hf, 0);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            add_read(rnd_addr[i], 0);
        end
    endtask

    task automatic check_data(string name, axil_data_t got, axil_data_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(string name, axil_resp_t got, axil_resp_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int unsigned got, int unsigned exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic run_entry(test_entry_t e, int idx);
        int unsigned errs_before;
        int unsigned cs_before [NR_CS];
        int unsigned ck_en_before;
        int unsigned rwds_oe_before;
        int unsigned reset_low_before;
        int unsigned chip;
        axil_data_t  got_data;
        axil_resp_t  got_resp;
        errs_before      = err_cnt;
        cs_before        = cs_low_cnt;
        ck_en_before     = ck_en_cnt;
        rwds_oe_before   = rwds_oe_cnt;
        reset_low_before = reset_low_cnt;
        chip             = e.addr >> CHIP_ADDR_BITS;
        @(posedge clk0);
        if (e.write) begin
            axil_req.aw.valid <= 1'b1;
            axil_req.aw.addr  <= e.addr;
            axil_req.w.valid  <= 1'b1;
            axil_req.w.data   <= e.data;
            axil_req.w.strb   <= e.strb;
        end else begin
            axil_req.ar.valid <= 1'b1;
            axil_req.ar.addr  <= e.addr;
        end
        do @(negedge clk0);
        while (!(e.write ? (axil_rsp.aw_ready && axil_rsp.w_ready) : axil_rsp.ar_ready));
        @(posedge clk0);
        axil_req.aw.valid <= 1'b0;
        axil_req.w.valid  <= 1'b0;
        axil_req.ar.valid <= 1'b0;
        do @(negedge clk0);
        while (!(e.write ? axil_rsp.b.valid : axil_rsp.r.valid));
        got_resp = e.write ? axil_rsp.b.resp : axil_rsp.r.resp;
        got_data = axil_rsp.r.data;
        // response held while a new read competes for the slave
        for (int i = 0; i < e.hold; i++) begin
            @(posedge clk0);
            axil_req.ar.valid <= 1'b1;
            axil_req.ar.addr  <= e.addr;
            @(negedge clk0);
            if (!(e.write ? axil_rsp.b.valid : axil_rsp.r.valid)) begin
                err_cnt++;
                $display("response valid dropped at %0t ns while ready was low", $time);
            end
            check_resp("resp during hold", e.write ? axil_rsp.b.resp : axil_rsp.r.resp,
                       got_resp);
            if (!e.write) check_data("rdata during hold", axil_rsp.r.data, got_data);
            if (axil_rsp.ar_ready) begin
                err_cnt++;
                $display("new read accepted at %0t ns before the response was taken", $time);
            end
        end
        @(posedge clk0);
        axil_req.ar.valid <= 1'b0;
        axil_req.b_ready  <= e.write;
        axil_req.r_ready  <= !e.write;
        @(posedge clk0);
        axil_req.b_ready  <= 1'b0;
        axil_req.r_ready  <= 1'b0;
        check_resp(e.write ? "bresp" : "rresp", got_resp, e.exp_resp);
        if (!e.write) check_data("rdata", got_data, e.exp_data);
        for (int c = 0; c < NR_CS; c++) begin
            check_count($sformatf("cs_low[%0d]", c), cs_low_cnt[c] - cs_before[c],
                        (e.exp_resp == RESP_OKAY && chip == c) ? CS_LOW_CYCLES : 0);
        end
        check_count("ck_en cycles", ck_en_cnt - ck_en_before,
                    (e.exp_resp == RESP_OKAY) ? CS_LOW_CYCLES : 0);
        check_count("rwds_oe cycles", rwds_oe_cnt - rwds_oe_before,
                    (e.exp_resp == RESP_OKAY && e.write) ? WR_DATA_CYCLES : 0);
        check_count("reset_n low cycles", reset_low_cnt - reset_low_before, 0);
        $display("test %2d %s addr %h: %s", idx, e.write ? "write" : "read ", e.addr,
                 (err_cnt == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        axil_req <= '0;
        rst_ni   <= 1'b0;
        build_table();
        timeout_limit = RESET_CYCLES + table_q.size() * CYCLES_PER_TEST;
        repeat (RESET_CYCLES) @(posedge clk0);
        rst_ni <= 1'b1;
        foreach (table_q[i]) begin
            run_entry(table_q[i], i);
        end
        repeat (2) @(posedge clk0);
        if (dut.i_phy.i_props.fail_cnt != 0) begin
            $display("%0d assertion failures in the phy", dut.i_phy.i_props.fail_cnt);
            err_cnt += dut.i_phy.i_props.fail_cnt;
        end
        $display("%0d tests, %0d checks, %0d errors", table_q.size(), check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_hyperram_model.sv
//////////////////////////////
// hyperram model
// byte memory behind one chip select, fixed latency,
// rwds high on every read data cycle
//////////////////////////////

module tb_hyperram_model #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned MEM_BYTES   = 256,
    parameter logic [7:0]  FILL_SEED   = 8'h00
) (
    input  logic                   clk0,
    input  logic                   cs_ni,
    input  logic                   dq_oe_i,
    input  hyper_pkg::hyper_word_t dq_i,
    input  hyper_pkg::hyper_mask_t rwds_i,
    output hyper_pkg::hyper_word_t dq_o,
    output logic                   rwds_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import hyper_pkg::*;

    localparam int unsigned DATA_START = 3 + 2 * WAIT_CYCLES;  // ca plus both latencies

    logic [7:0]   mem [MEM_BYTES];
    hyper_ca_t    ca_q;
    int unsigned  cyc_q = 0;        // cycles since cs went low
    hyper_haddr_t haddr;
    int unsigned  idx;              // byte index of the halfword high byte
    logic         in_data;
    logic         rd_drive;

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ FILL_SEED;
        end
    end

    assign haddr    = hyper_haddr_t'({ca_q[CA_UPPER_MSB:CA_UPPER_LSB],
                                      ca_q[CA_LOWER_BITS-1:0]});
    assign in_data  = !cs_ni && (cyc_q >= DATA_START) && (cyc_q < DATA_START + 2);
    assign idx      = ((32'(haddr) + cyc_q - DATA_START) * 2) % MEM_BYTES;  // linear burst
    assign rd_drive = in_data && !dq_oe_i && ca_q[CA_RW_BIT];

    always @(posedge clk0) begin
        if (cs_ni) begin
            cyc_q <= 0;
        end else begin
            cyc_q <= cyc_q + 1;
            if (cyc_q < 3) begin
                ca_q[(2 - cyc_q) * 16 +: 16] <= dq_i;   // ca arrives msb halfword first
            end
            if (in_data && dq_oe_i && !ca_q[CA_RW_BIT]) begin
                if (!rwds_i[1]) mem[idx]     <= dq_i[15:8];
                if (!rwds_i[0]) mem[idx + 1] <= dq_i[7:0];
            end
        end
    end

    assign dq_o   = rd_drive ? {mem[idx], mem[idx + 1]} : '0;
    assign rwds_o = rd_drive;

endmodule
